//--- flist.f
+incdir+testbench
design/elevatorPkg.sv
design/lcdHostIf.sv
design/floorRequestLatch.sv
design/carMotion.sv
design/segmentPanel.sv
design/lcdMessageSequencer.sv
design/lcdWriteCycle.sv
design/elevatorTop.sv
testbench/elevatorTb.sv

//--- runSim.sh
#!/bin/sh
# Build the elevator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f flist.f --top-module elevatorTb -o elevatorSim \
	&& ./obj_dir/elevatorSim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- testbench/elevatorTbTasks.svh
`ifndef elevatorTbTasksSvh
`define elevatorTbTasksSvh

	task automatic checkFloorSeg(input segT got, input segT exp, input string what);
		if (got !== exp)
		begin
			segErrors++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkPattern(input dirPatternT got, input dirPatternT exp, input string what);
		if (got !== exp)
		begin
			patternErrors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkLcdEntry(input lcdEntryT got, input lcdEntryT exp, input string what);
		if (got !== exp)
		begin
			lcdErrors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic levelCheck(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			otherErrors++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Request loads 3 edges after the key goes high
	task automatic pressKey(input logic [numFloors-1:0] sw);
		floorSwitch = sw;
		callKey     = 1'b1;
		repeat (3) @(negedge iCLK);
		callKey = 1'b0;
	endtask

	function automatic segT floorSeg(input floorT f);
		return (f == 0) ? segDash : segDigits[f]; // Dash before the first request
	endfunction

	function automatic floorT lowestFloor(input logic [numFloors-1:0] sw, input floorT old);
		for (int i = 0; i < numFloors; i++)
			if (sw[i])
				return floorT'(i + 1); // First set switch from floor 1 up
		return old; // No switch keeps the request
	endfunction

	// Text character with r and c replaced by floor digits
	function automatic lcdByteT textChar(input string text, input int pos,
		input floorT r, input floorT c);
		lcdByteT ch;
		floorT   f;
		ch = text[pos];
		if (ch != "r" && ch != "c")
			return ch;
		f = (ch == "r") ? r : c;
		return (f == 0) ? 8'h3A : 8'h30 + {4'h0, f}; // Colon for no floor
	endfunction

	// Entry k of the status message for one logged state
	function automatic lcdEntryT expectedEntry(input int k, input logic [9:0] st);
		string    line1;
		string    line2;
		lcdEntryT e;
		line1 = " AT FLOOR (c) :)"; // Idle screen
		line2 = "                ";
		if (st[9:8] == dirUp)
			line1 = " GOING UP TO (r)";
		else if (st[9:8] == dirDown)
			line1 = " GOING DOWN TO r";
		if (st[9:8] == dirUp || st[9:8] == dirDown)
			line2 = " AT FLOOR (c) :)";
		case (k)
			0:  e = 9'h038; // Function set
			1:  e = 9'h00C;
			2:  e = 9'h001; // Clear
			3:  e = 9'h006;
			4:  e = 9'h080;
			21: e = 9'h0C0; // Line 2
			default:
				if (k < 21)
					e = {1'b1, textChar(line1, k - 5, st[7:4], st[3:0])};
				else
					e = {1'b1, textChar(line2, k - 22, st[7:4], st[3:0])};
		endcase
		return e;
	endfunction

`endif

//--- testbench/elevatorTb.sv
`timescale 1ns/10ps

module elevatorTb;
	import elevatorPkg::*;

	localparam int tbTravelCycles = 40; // Short floor step
	localparam int tbHoldCycles   = 3;
	localparam int stepMargin     = 4;  // Slack per floor step
	localparam int entryCycles    = lcdEnableCycles + tbHoldCycles + 12; // Upper bound per LCD entry
	// Travel, settling and up to three messages per LCD capture
	localparam int runCycles = (3 * numFloors + 10) * (tbTravelCycles + stepMargin)
		+ 6 * lcdMsgLen * entryCycles + 500;

	logic                 iCLK;
	logic                 rstN;
	logic [numFloors-1:0] floorSwitch;
	logic                 callKey;
	segT                  requestSeg;
	segT                  currentSeg;
	dirPatternT           directionPattern;
	lcdByteT              lcdData;
	logic                 lcdEn;
	logic                 lcdRs;

	int    segErrors;
	int    patternErrors;
	int    lcdErrors;
	int    otherErrors;  // Levels and timeouts
	floorT trackFloor;   // Where the car should be
	floorT reqModel;     // Request the latch should hold

	logic [9:0] stateLog [$]; // {direction, request, current} each cycle
	lcdEntryT   capEntry [$]; // {rs, byte} at each enable fall
	int         capFirst [$]; // State window of each entry
	int         capLast  [$];
	int         winStart = 0;

	`include "elevatorTbTasks.svh"

	elevatorTop #(.travelCycles(tbTravelCycles), .holdCycles(tbHoldCycles)) dut_i
	(
		.iCLK             (iCLK),
		.rstN             (rstN),
		.floorSwitch      (floorSwitch),
		.callKey          (callKey),
		.requestSeg       (requestSeg),
		.currentSeg       (currentSeg),
		.directionPattern (directionPattern),
		.lcdData          (lcdData),
		.lcdEn            (lcdEn),
		.lcdRs            (lcdRs)
	);

	always #4 iCLK = ~iCLK; // 8 ns period

	always @(negedge iCLK)
		stateLog.push_back({dut_i.direction, dut_i.requestFloor, dut_i.currentFloor});

	// LCD latches on the enable fall
	always @(negedge lcdEn)
	begin
		if (rstN === 1'b1)
		begin
			capEntry.push_back({lcdRs, lcdData});
			capFirst.push_back(winStart); // States since the last write
			capLast.push_back(stateLog.size() - 1);
			winStart = stateLog.size();
		end
	end

	initial
	begin
		#(longint'(runCycles) * 8);
		$display("Watchdog timeout after %0d cycles, the tests did not finish", runCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic resetCheck();
		checkFloorSeg(requestSeg, segDash, "request digit after reset");
		checkFloorSeg(currentSeg, segDash, "current digit after reset");
		checkPattern(directionPattern, patIdle, "pattern after reset");
		levelCheck(lcdEn, 1'b0, "lcdEn after reset");
	endtask

	// Request one floor and follow the car step by step
	task automatic travelTo(input floorT target);
		floorT      prevFloor;
		floorT      nextFloor;
		dirPatternT expPat;
		int         waited;
		expPat    = (target > trackFloor) ? patUp : patDown;
		prevFloor = trackFloor;
		pressKey(numFloors'(1 << (target - 1)));
		reqModel = target;
		checkFloorSeg(requestSeg, floorSeg(target), "request digit");
		@(negedge iCLK); // Direction one clock after the request
		while (prevFloor != target)
		begin
			nextFloor = (target > prevFloor) ? prevFloor + 4'd1 : prevFloor - 4'd1;
			waited    = 0;
			while (currentSeg !== floorSeg(nextFloor) && waited <= tbTravelCycles + stepMargin)
			begin
				checkFloorSeg(currentSeg, floorSeg(prevFloor), "current digit in travel");
				checkPattern(directionPattern, expPat, "pattern in travel");
				@(negedge iCLK);
				waited++;
			end
			if (currentSeg !== floorSeg(nextFloor))
			begin
				$display("Car did not reach floor %0d within %0d cycles", nextFloor, waited);
				otherErrors++;
				return;
			end
			prevFloor = nextFloor;
		end
		repeat (2) @(negedge iCLK);
		checkPattern(directionPattern, patIdle, "pattern at arrival");
		trackFloor = target;
	endtask

	task automatic requestCapture();
		logic [numFloors-1:0] sw;
		int                   waited;
		for (int n = 0; n < 7; n++)
		begin
			sw = numFloors'($urandom);
			if (sw == '0)
				sw = 4'b0010;
			if (n == 6)
				sw = '0; // Last press with no switch
			reqModel = lowestFloor(sw, reqModel);
			pressKey(sw);
			checkFloorSeg(requestSeg, floorSeg(reqModel), "request digit after press");
			repeat (4) @(negedge iCLK); // Key settles low
		end
		waited = 0;
		while ((currentSeg !== floorSeg(reqModel) || directionPattern !== patIdle)
			&& waited < numFloors * (tbTravelCycles + stepMargin))
		begin
			@(negedge iCLK);
			waited++;
		end
		if (currentSeg !== floorSeg(reqModel) || directionPattern !== patIdle)
		begin
			$display("Car did not come to rest on floor %0d", reqModel);
			otherErrors++;
		end
		trackFloor = reqModel;
	endtask

	// One full message from its first command; bounce keeps the car moving
	task automatic lcdMessageCheck(input string label, input bit bounce);
		int       i;
		int       first;
		int       keyHold;
		bit       seenC0;
		floorT    target;
		lcdEntryT exp;
		i       = capEntry.size();
		first   = -1;
		seenC0  = 1'b0;
		keyHold = 0;
		target  = trackFloor;
		while (first < 0 || capEntry.size() < first + lcdMsgLen)
		begin
			@(negedge iCLK);
			if (bounce && keyHold > 0)
			begin
				keyHold--;
				if (keyHold == 0)
					callKey = 1'b0;
			end
			else if (bounce && dut_i.currentFloor == target && dut_i.direction == dirIdle)
			begin
				target      = (target == floorT'(numFloors)) ? 4'd1 : floorT'(numFloors);
				floorSwitch = numFloors'(1 << (target - 1)); // Other end of the shaft
				callKey     = 1'b1;
				keyHold     = 3;
			end
			while (first < 0 && i < capEntry.size())
			begin
				if (capEntry[i] == 9'h0C0)
					seenC0 = 1'b1;
				else if (seenC0 && capEntry[i] == 9'h038)
					first = i; // Message start
				i++;
			end
		end
		callKey = 1'b0;
		for (int k = 0; k < lcdMsgLen; k++)
		begin
			exp = expectedEntry(k, stateLog[capLast[first + k]]);
			for (int s = capFirst[first + k]; s <= capLast[first + k]; s++)
				if (expectedEntry(k, stateLog[s]) === capEntry[first + k])
					exp = capEntry[first + k]; // Fetched while this state held
			checkLcdEntry(capEntry[first + k], exp, $sformatf("%s entry %0d", label, k));
		end
	endtask

	initial
	begin
		iCLK          = 1'b0;
		rstN          = 1'b0;
		floorSwitch   = '0;
		callKey       = 1'b0;
		segErrors     = 0;
		patternErrors = 0;
		lcdErrors     = 0;
		otherErrors   = 0;
		trackFloor    = '0;
		reqModel      = '0;
		void'($urandom(45701));
		repeat (5) @(negedge iCLK);
		rstN = 1'b1;
		resetCheck();
		travelTo(floorT'(numFloors));
		travelTo(4'd1);
		requestCapture();
		lcdMessageCheck("idle", 1'b0);
		lcdMessageCheck("moving", 1'b1);
		$display("Errors: segment %0d, pattern %0d, lcd %0d, other %0d",
			segErrors, patternErrors, lcdErrors, otherErrors);
		if (segErrors + patternErrors + lcdErrors + otherErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- design/elevatorTop.sv
`timescale 1ns/10ps

module elevatorTop #(
	parameter int travelCycles = elevatorPkg::defTravelCycles, // Cycles per floor
	parameter int holdCycles   = elevatorPkg::defHoldCycles    // Pause between LCD entries
)
(
	input  logic                            iCLK,
	input  logic                            rstN,
	input  logic [elevatorPkg::numFloors-1:0] floorSwitch, // Switch 0 = floor 1
	input  logic                            callKey,          // Push-button, asynchronous
	output elevatorPkg::segT                requestSeg,
	output elevatorPkg::segT                currentSeg,
	output elevatorPkg::dirPatternT         directionPattern,
	output elevatorPkg::lcdByteT            lcdData,
	output logic                            lcdEn,
	output logic                            lcdRs
);
	import elevatorPkg::*;

	floorT requestFloor; // Latched target
	floorT currentFloor; // Where the car is
	dirT   direction;

	lcdHostIf lcdBus(); // Sequencer to write controller

	floorRequestLatch requestLatch_i
	(
		.iCLK         (iCLK),
		.rstN         (rstN),
		.floorSwitch  (floorSwitch),
		.callKey      (callKey),
		.requestFloor (requestFloor)
	);

	carMotion #(.travelCycles(travelCycles)) car_i
	(
		.iCLK         (iCLK),
		.rstN         (rstN),
		.requestFloor (requestFloor),
		.currentFloor (currentFloor),
		.direction    (direction)
	);

	segmentPanel panel_i
	(
		.requestFloor     (requestFloor),
		.currentFloor     (currentFloor),
		.direction        (direction),
		.requestSeg       (requestSeg),
		.currentSeg       (currentSeg),
		.directionPattern (directionPattern)
	);

	lcdMessageSequencer #(.holdCycles(holdCycles)) lcdSeq_i
	(
		.iCLK         (iCLK),
		.rstN         (rstN),
		.requestFloor (requestFloor),
		.currentFloor (currentFloor),
		.direction    (direction),
		.lcd          (lcdBus.host)
	);

	lcdWriteCycle lcdWrite_i
	(
		.iCLK    (iCLK),
		.rstN    (rstN),
		.lcd     (lcdBus.device),
		.lcdData (lcdData),
		.lcdEn   (lcdEn),
		.lcdRs   (lcdRs)
	);

endmodule

//--- design/lcdWriteCycle.sv
`timescale 1ns/10ps

module lcdWriteCycle
(
	input  logic                 iCLK,
	input  logic                 rstN,
	lcdHostIf.device             lcd,
	output elevatorPkg::lcdByteT lcdData,
	output logic                 lcdEn,  // Write strobe to the LCD
	output logic                 lcdRs
);
	import elevatorPkg::*;

	typedef enum logic [1:0]
	{
		wcIdle,   // Wait for a start edge
		wcSetup,  // Data and rs settle
		wcEnable, // Raise enable
		wcHold    // Stretch enable
	} wcStateT;

	wcStateT                              wcState;
	logic                                 startPrev;
	logic                                 startEdge;
	logic [$clog2(lcdEnableCycles+1)-1:0] enCount; // Enable high time

	assign startEdge = lcd.start & ~startPrev;

	// Data and rs go straight to the pins
	assign lcdData = lcd.data;
	assign lcdRs   = lcd.rs;

	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			wcState   <= wcIdle;
			startPrev <= 1'b0;
			enCount   <= '0;
			lcdEn     <= 1'b0;
			lcd.done  <= 1'b0;
		end
		else
		begin
			startPrev <= lcd.start;
			case (wcState)
				wcIdle:
				begin
					if (startEdge)
					begin
						lcd.done <= 1'b0; // New write in progress
						wcState  <= wcSetup;
					end
				end
				wcSetup: wcState <= wcEnable;
				wcEnable:
				begin
					lcdEn   <= 1'b1;
					enCount <= '0;
					wcState <= wcHold;
				end
				default:
				begin
					if (enCount == $bits(enCount)'(lcdEnableCycles))
					begin
						lcdEn    <= 1'b0; // Falling edge latches the byte
						lcd.done <= 1'b1;
						wcState  <= wcIdle;
					end
					else
						enCount <= enCount + 1'b1;
				end
			endcase
		end
	end

endmodule

//--- design/lcdMessageSequencer.sv
`timescale 1ns/10ps

module lcdMessageSequencer #(
	parameter int holdCycles = elevatorPkg::defHoldCycles // Pause after each entry
)
(
	input  logic               iCLK,
	input  logic               rstN,
	input  elevatorPkg::floorT requestFloor,
	input  elevatorPkg::floorT currentFloor,
	input  elevatorPkg::dirT   direction,
	lcdHostIf.host             lcd
);
	import elevatorPkg::*;

	typedef enum logic [2:0]
	{
		seqFetch,   // Sample the entry
		seqStart,   // Raise start, wait for done to clear
		seqWait,    // Wait for the write to finish
		seqHold,    // Pause
		seqAdvance  // Next index
	} seqStateT;

	seqStateT                        seqState;
	lcdIndexT                        msgIndex;  // Entry 0 to 37
	logic [$clog2(holdCycles+1)-1:0] holdCount;
	lcdEntryT                        msgEntry;  // Entry at msgIndex, live
	lcdEntryT                        entryReg;  // Entry being written
	lcdLineT                         line1Text;
	lcdLineT                         line2Text;

	// ASCII digit for a floor, colon for no floor
	function automatic lcdByteT floorChar(input floorT floorNum);
		lcdByteT ch;
		if (floorNum >= 4'd1 && floorNum <= floorT'(numFloors))
			ch = 8'h30 + {4'h0, floorNum};
		else
			ch = 8'h3A; // ':'
		return ch;
	endfunction

	// Character pos of a line with the floor placeholders filled in
	function automatic lcdByteT lineChar(input lcdLineT text, input lcdIndexT pos,
		input floorT reqFloor, input floorT curFloor);
		lcdByteT ch;
		ch = text[8*(lcdLineLen-1-int'(pos)) +: 8];
		if (ch == "r")
			ch = floorChar(reqFloor);
		else if (ch == "c")
			ch = floorChar(curFloor);
		return ch;
	endfunction

	// Screen text depends on direction
	always_comb
	begin
		case (direction)
			dirUp:
			begin
				line1Text = txtUp;
				line2Text = txtAt;
			end
			dirDown:
			begin
				line1Text = txtDown;
				line2Text = txtAt;
			end
			default:
			begin
				line1Text = txtAt; // Idle shows the floor on top
				line2Text = txtBlank;
			end
		endcase
	end

	// Init commands, line 1, line change, line 2
	always_comb
	begin
		if (msgIndex < lcdIndexT'(lcdInitLen))
			msgEntry = {1'b0, lcdInitCmds[msgIndex[2:0]]};
		else if (msgIndex < lcdIndexT'(lcdInitLen + lcdLineLen))
			msgEntry = {1'b1, lineChar(line1Text, msgIndex - lcdIndexT'(lcdInitLen),
				requestFloor, currentFloor)};
		else if (msgIndex == lcdIndexT'(lcdInitLen + lcdLineLen))
			msgEntry = {1'b0, lcdLine2Cmd};
		else
			msgEntry = {1'b1, lineChar(line2Text, msgIndex - lcdIndexT'(lcdInitLen + lcdLineLen + 1),
				requestFloor, currentFloor)};
	end

	assign lcd.data = entryReg[7:0];
	assign lcd.rs   = entryReg[8];

	always_ff @(posedge iCLK)
		if (seqState == seqFetch)
			entryReg <= msgEntry; // Floors frozen for this entry

	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			seqState  <= seqFetch;
			msgIndex  <= '0;
			holdCount <= '0;
			lcd.start <= 1'b0;
		end
		else
		begin
			case (seqState)
				seqFetch: seqState <= seqStart;
				seqStart:
				begin
					lcd.start <= 1'b1;
					if (!lcd.done)
						seqState <= seqWait; // Old done is gone
				end
				seqWait:
				begin
					if (lcd.done)
					begin
						lcd.start <= 1'b0;
						seqState  <= seqHold;
					end
				end
				seqHold:
				begin
					if (holdCount == $bits(holdCount)'(holdCycles - 1))
					begin
						holdCount <= '0;
						seqState  <= seqAdvance;
					end
					else
						holdCount <= holdCount + 1'b1;
				end
				default:
				begin
					if (msgIndex == lcdIndexT'(lcdMsgLen - 1))
						msgIndex <= '0; // Rewrite the whole screen
					else
						msgIndex <= msgIndex + 1'b1;
					seqState <= seqFetch;
				end
			endcase
		end
	end

endmodule

//--- design/segmentPanel.sv
`timescale 1ns/10ps

module segmentPanel
(
	input  elevatorPkg::floorT      requestFloor,
	input  elevatorPkg::floorT      currentFloor,
	input  elevatorPkg::dirT        direction,
	output elevatorPkg::segT        requestSeg,       // Request digit
	output elevatorPkg::segT        currentSeg,       // Current digit
	output elevatorPkg::dirPatternT directionPattern  // Four-digit word
);
	import elevatorPkg::*;

	// Digit code for a floor, dash for 0 or anything out of range
	function automatic segT floorToSeg(input floorT floorNum);
		segT code;
		if (floorNum >= 4'd1 && floorNum <= floorT'(numFloors))
			code = segDigits[floorNum];
		else
			code = segDash;
		return code;
	endfunction

	assign requestSeg = floorToSeg(requestFloor);
	assign currentSeg = floorToSeg(currentFloor);

	always_comb
	begin
		case (direction)
			dirUp:   directionPattern = patUp;
			dirDown: directionPattern = patDown;
			default: directionPattern = patIdle; // Idle and unused code
		endcase
	end

endmodule

//--- design/carMotion.sv
`timescale 1ns/10ps

module carMotion #(
	parameter int travelCycles = elevatorPkg::defTravelCycles // Cycles per floor step
)
(
	input  logic               iCLK,
	input  logic               rstN,
	input  elevatorPkg::floorT requestFloor,
	output elevatorPkg::floorT currentFloor,
	output elevatorPkg::dirT   direction
);
	import elevatorPkg::*;

	logic [$clog2(travelCycles+1)-1:0] travelTimer; // Cycles spent on this step
	logic                              stepDue;     // Timer at its last count

	assign stepDue = (travelTimer == $bits(travelTimer)'(travelCycles - 1));

	// Target compared every cycle, so a new request redirects the car at once
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			currentFloor <= '0; // Reset floor
			direction    <= dirIdle;
			travelTimer  <= '0;
		end
		else if (requestFloor > currentFloor)
		begin
			direction <= dirUp;
			if (stepDue)
			begin
				currentFloor <= currentFloor + 4'd1; // One floor up
				travelTimer  <= '0; // Restart for next floor
			end
			else
				travelTimer <= travelTimer + 1'b1;
		end
		else if (requestFloor < currentFloor)
		begin
			direction <= dirDown;
			if (stepDue)
			begin
				currentFloor <= currentFloor - 4'd1; // One floor down
				travelTimer  <= '0;
			end
			else
				travelTimer <= travelTimer + 1'b1;
		end
		else
		begin
			direction   <= dirIdle; // Arrived
			travelTimer <= '0;
		end
	end

endmodule

//--- design/floorRequestLatch.sv
`timescale 1ns/10ps

module floorRequestLatch
(
	input  logic                              iCLK,
	input  logic                              rstN,
	input  logic [elevatorPkg::numFloors-1:0] floorSwitch, // Bit i selects floor i+1
	input  logic                              callKey,     // Raw push-button
	output elevatorPkg::floorT                requestFloor
);
	import elevatorPkg::*;

	logic [1:0] keySync; // Two-stage synchronizer
	logic       keyPrev; // Last synchronized level
	logic       keyRise; // One cycle per press
	floorT      pickFloor; // Candidate from the switches

	assign keyRise = keySync[1] & ~keyPrev;

	// Lowest switch wins, so scan from the top down
	always_comb
	begin
		pickFloor = requestFloor; // No switch set, keep request
		for (int i = numFloors - 1; i >= 0; i--)
		begin
			if (floorSwitch[i])
				pickFloor = floorT'(i + 1);
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			keySync      <= 2'b00;
			keyPrev      <= 1'b0;
			requestFloor <= '0; // No floor yet
		end
		else
		begin
			keySync <= {keySync[0], callKey}; // Shift in raw key
			keyPrev <= keySync[1];
			if (keyRise)
				requestFloor <= pickFloor; // Load on press only
		end
	end

endmodule

//--- design/lcdHostIf.sv
`timescale 1ns/10ps

interface lcdHostIf;
	import elevatorPkg::*;

	lcdByteT data; // Byte for the LCD
	logic    rs;   // 0 command, 1 character
	logic    start; // Held high until done
	logic    done;  // Set when the enable pulse ends

	modport host
	(
		output data, rs, start,
		input  done
	);

	modport device
	(
		input  data, rs, start,
		output done
	);

endinterface

//--- design/elevatorPkg.sv
package elevatorPkg;

	localparam int numFloors = 4; // Real floors 1 to 4

	typedef logic [3:0] floorT; // 0 = no floor yet

	typedef enum logic [1:0]
	{
		dirIdle = 2'd0,
		dirUp   = 2'd1,
		dirDown = 2'd2
	} dirT;

	// Seven-segment panel, segments active low
	typedef logic [6:0] segT;
	typedef logic [27:0] dirPatternT; // Four digits of segT

	localparam segT segDash = 7'b1111110; // Middle bar only
	localparam segT segDigits [1:numFloors] = '{
		7'b1001111, // 1
		7'b0010010, // 2
		7'b0000110, // 3
		7'b1001100  // 4
	};

	localparam dirPatternT patUp   = 28'b1111111111111100110001000001; // UP
	localparam dirPatternT patDown = 28'b0011000100000100010010000001; // DOWN
	localparam dirPatternT patIdle = 28'b0001001000000111111111111111; // Standing

	// Character LCD
	typedef logic [7:0] lcdByteT;
	typedef logic [8:0] lcdEntryT; // {rs, byte}
	typedef logic [5:0] lcdIndexT;

	localparam int lcdInitLen = 5;
	localparam int lcdLineLen = 16;
	localparam int lcdMsgLen  = lcdInitLen + lcdLineLen + 1 + lcdLineLen; // 38 entries

	typedef logic [8*lcdLineLen-1:0] lcdLineT; // First character in the top byte

	localparam lcdByteT lcdInitCmds [0:lcdInitLen-1] = '{
		8'h38, // 8-bit bus, two lines
		8'h0C, // Display on, no cursor
		8'h01, // Clear
		8'h06, // Entry mode, increment
		8'h80  // Home on line 1
	};
	localparam lcdByteT lcdLine2Cmd = 8'hC0; // Cursor to line 2

	// Line texts; r and c are replaced by the request and current floor
	localparam lcdLineT txtUp    = " GOING UP TO (r)";
	localparam lcdLineT txtDown  = " GOING DOWN TO r";
	localparam lcdLineT txtAt    = " AT FLOOR (c) :)";
	localparam lcdLineT txtBlank = "                ";

	localparam int lcdEnableCycles = 16; // Enable pulse stretch

	// Board defaults, about 1.3 s per floor at 50 MHz
	localparam int defTravelCycles = 2 ** 26;
	localparam int defHoldCycles   = 'h3FFFE; // Pause after each LCD byte

endpackage
